/* common/acc16_pkg.sv */
package acc16_pkg;

	// instruction word is three bytes, opcode in the low byte
	localparam int INST_W = 24;
	localparam int OPC_LSB = 0;
	localparam int IMM_LSB = 8;

	localparam int FLAG_W = 5;
	localparam int FLAG_H = 0;
	localparam int FLAG_C = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_Z = 3;
	localparam int FLAG_O = 4;

	localparam logic [15:0] RESET_PC = 16'h4000;

	typedef enum logic [7:0] {
		OP_NOP         = 8'h00,
		OP_LD_XL_IMMD  = 8'h10,
		OP_ADD_XL_IMMD = 8'h11,
		OP_SUB_XL_IMMD = 8'h12,
		OP_AND_XL_IMMD = 8'h13,
		OP_OR_XL_IMMD  = 8'h14,
		OP_XOR_XL_IMMD = 8'h15,
		OP_INC_XL      = 8'h16,
		OP_LD_XL_DIR   = 8'h20,
		OP_LD_DIR_XL   = 8'h21,
		OP_LDW_Y_IMMD  = 8'h30,
		OP_ADDW_Y_X    = 8'h31,
		OP_LDW_DIR_Y   = 8'h32,
		OP_JP_IMMD     = 8'h40,
		OP_JR_D        = 8'h41,
		OP_JRZ_D       = 8'h42,
		OP_JRNZ_D      = 8'h43,
		OP_JRC_D       = 8'h44,
		OP_JRNC_D      = 8'h45,
		OP_TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_PASS8,
		ALU_PASS16,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_ADDW
	} alu_op_t;

	// unknown opcodes count as one byte
	function automatic logic [1:0] inst_len(input opcode_t op);
		case (op)
		OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD,
		OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_JR_D, OP_JRZ_D, OP_JRNZ_D,
		OP_JRC_D, OP_JRNC_D:
			return 2'd2;
		OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_IMMD, OP_LDW_DIR_Y, OP_JP_IMMD:
			return 2'd3;
		default:
			return 2'd1;
		endcase
	endfunction

endpackage

/* common/alu_if.sv */
`timescale 1ns/1ps

interface alu_if
	import acc16_pkg::*;
();
	alu_op_t op;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] result;
	logic c;
	logic z;
	logic n;
	logic h;
	logic o;

	modport decoder_mp (output op, a, b, input result, c, z, n, h, o);

	modport alu_mp (input op, a, b, output result, c, z, n, h, o);

endinterface

/* core/alu.sv */
`timescale 1ns/1ps

module alu
	import acc16_pkg::*;
(
	alu_if.alu_mp alu
);
	logic wide;
	logic cin;
	logic [15:0] opa;
	logic [15:0] opb;
	logic [16:0] sum;
	logic [4:0] nib;
	logic [15:0] res;
	logic top_a;
	logic top_b;
	logic top_r;

	// sub is a + ~b + 1, so c ends up set when no borrow
	always_comb
	begin
		wide = (alu.op == ALU_PASS16) || (alu.op == ALU_ADDW);
		opa = wide ? alu.a : {8'h00, alu.a[7:0]};
		opb = wide ? alu.b : {8'h00, alu.b[7:0]};
		cin = 1'b0;
		case (alu.op)
		ALU_SUB:
		begin
			opb = {8'h00, ~alu.b[7:0]};
			cin = 1'b1;
		end
		ALU_INC:
		begin
			opb = 16'h0000;
			cin = 1'b1;
		end
		default:
			cin = 1'b0;
		endcase
	end

	assign sum = {1'b0, opa} + {1'b0, opb} + {16'h0000, cin};
	assign nib = {1'b0, opa[3:0]} + {1'b0, opb[3:0]} + {4'h0, cin};

	always_comb
	begin
		case (alu.op)
		ALU_PASS8: res = {8'h00, alu.b[7:0]};
		ALU_PASS16: res = alu.b;
		ALU_AND: res = {8'h00, alu.a[7:0] & alu.b[7:0]};
		ALU_OR: res = {8'h00, alu.a[7:0] | alu.b[7:0]};
		ALU_XOR: res = {8'h00, alu.a[7:0] ^ alu.b[7:0]};
		default: res = wide ? sum[15:0] : {8'h00, sum[7:0]};
		endcase
	end

	assign top_a = wide ? opa[15] : opa[7];
	assign top_b = wide ? opb[15] : opb[7];
	assign top_r = wide ? res[15] : res[7];

	assign alu.result = res;
	assign alu.c = wide ? sum[16] : sum[8];
	assign alu.z = wide ? (res == 16'h0000) : (res[7:0] == 8'h00);
	assign alu.n = top_r;
	assign alu.h = nib[4];
	// signed overflow, operands agree in sign but result does not
	assign alu.o = (top_a == top_b) && (top_r != top_a);

endmodule

/* core/decoder.sv */
`timescale 1ns/1ps

module decoder
	import acc16_pkg::*;
#(
	parameter int ADDR_W = 16
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [INST_W-1:0] inst,
	input  logic [15:0]       dread_data,
	input  logic [15:0]       x,
	input  logic [15:0]       y,
	input  logic [15:0]       z,
	input  logic [FLAG_W-1:0] flags,
	output logic [FLAG_W-1:0] next_flags,
	alu_if.decoder_mp         alu,
	output logic [1:0]        reg_addr,
	output logic [15:0]       reg_data,
	output logic [1:0]        reg_en,
	output logic [ADDR_W-1:0] dwrite_addr,
	output logic [15:0]       dwrite_data,
	output logic [1:0]        dwrite_en,
	output logic              trap
);
	opcode_t opcode;
	logic [7:0] imm8;
	logic [15:0] imm16;
	logic [1:0] store_en;
	logic upd_all;
	logic upd_zn;

	assign opcode = opcode_t'(inst[OPC_LSB +: 8]);
	assign imm8 = inst[IMM_LSB +: 8];
	assign imm16 = inst[IMM_LSB +: 16];

	always_comb
	begin
		alu.op = ALU_PASS8;
		alu.b = {8'h00, imm8};
		reg_addr = 2'd0;
		reg_en = 2'b00;
		store_en = 2'b00;
		upd_all = 1'b0;
		upd_zn = 1'b0;
		case (opcode)
		OP_LD_XL_IMMD:
			reg_en = 2'b01;
		OP_ADD_XL_IMMD:
		begin
			alu.op = ALU_ADD;
			reg_en = 2'b01;
			upd_all = 1'b1;
		end
		OP_SUB_XL_IMMD:
		begin
			alu.op = ALU_SUB;
			reg_en = 2'b01;
			upd_all = 1'b1;
		end
		OP_AND_XL_IMMD:
		begin
			alu.op = ALU_AND;
			reg_en = 2'b01;
			upd_zn = 1'b1;
		end
		OP_OR_XL_IMMD:
		begin
			alu.op = ALU_OR;
			reg_en = 2'b01;
			upd_zn = 1'b1;
		end
		OP_XOR_XL_IMMD:
		begin
			alu.op = ALU_XOR;
			reg_en = 2'b01;
			upd_zn = 1'b1;
		end
		OP_INC_XL:
		begin
			alu.op = ALU_INC;
			reg_en = 2'b01;
			upd_all = 1'b1;
		end
		OP_LD_XL_DIR:
		begin
			alu.b = dread_data;
			reg_en = 2'b01;
		end
		OP_LD_DIR_XL:
		begin
			alu.b = x;
			store_en = 2'b01;
		end
		OP_LDW_Y_IMMD:
		begin
			alu.op = ALU_PASS16;
			alu.b = imm16;
			reg_addr = 2'd1;
			reg_en = 2'b11;
		end
		OP_ADDW_Y_X:
		begin
			alu.op = ALU_ADDW;
			alu.b = x;
			reg_addr = 2'd1;
			reg_en = 2'b11;
			upd_all = 1'b1;
		end
		OP_LDW_DIR_Y:
		begin
			alu.op = ALU_PASS16;
			alu.b = y;
			store_en = 2'b11;
		end
		default:
			reg_en = 2'b00;
		endcase
	end

	// accumulator is whatever register gets written back
	always_comb
	begin
		case (reg_addr)
		2'd1: alu.a = y;
		2'd2: alu.a = z;
		default: alu.a = x;
		endcase
	end

	always_comb
	begin
		next_flags = flags;
		if (upd_all)
		begin
			next_flags[FLAG_H] = alu.h;
			next_flags[FLAG_C] = alu.c;
			next_flags[FLAG_O] = alu.o;
		end
		if (upd_all || upd_zn)
		begin
			next_flags[FLAG_N] = alu.n;
			next_flags[FLAG_Z] = alu.z;
		end
	end

	assign reg_data = alu.result;
	assign dwrite_addr = imm16[ADDR_W-1:0];
	assign dwrite_data = alu.result;
	assign dwrite_en = reset ? 2'b00 : store_en;

	always_ff @(posedge clk)
	begin
		if (reset)
			trap <= 1'b0;
		else
			trap <= (opcode == OP_TRAP);
	end

endmodule

/* core/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
	import acc16_pkg::*;
#(
	parameter int ADDR_W = 16
) (
	input  logic              clk,
	input  logic              reset,
	output logic [ADDR_W-1:0] iread_addr,
	input  logic [INST_W-1:0] iread_data,
	output logic [INST_W-1:0] inst,
	input  logic [FLAG_W-1:0] next_flags,
	output logic [ADDR_W-1:0] dread_addr
);
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] next_pc;
	opcode_t fetch_op;
	logic [7:0] disp;
	logic rel_taken;

	// pc is the address of the word on iread_data
	assign fetch_op = opcode_t'(iread_data[OPC_LSB +: 8]);
	assign disp = iread_data[IMM_LSB +: 8];

	// conditions see flags of the instruction now executing
	always_comb
	begin
		case (fetch_op)
		OP_JR_D: rel_taken = 1'b1;
		OP_JRZ_D: rel_taken = next_flags[FLAG_Z];
		OP_JRNZ_D: rel_taken = !next_flags[FLAG_Z];
		OP_JRC_D: rel_taken = next_flags[FLAG_C];
		OP_JRNC_D: rel_taken = !next_flags[FLAG_C];
		default: rel_taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = ADDR_W'(RESET_PC);
		else if (fetch_op == OP_JP_IMMD)
			next_pc = iread_data[IMM_LSB +: ADDR_W];
		else if (rel_taken)
			next_pc = pc + ADDR_W'(signed'(disp)) + ADDR_W'(2);
		else
			next_pc = pc + ADDR_W'(inst_len(fetch_op));
	end

	assign iread_addr = next_pc;
	assign dread_addr = (fetch_op == OP_LD_XL_DIR) ? iread_data[IMM_LSB +: ADDR_W] : '0;

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
			inst <= INST_W'(OP_NOP);
		else
			inst <= iread_data;
	end

endmodule

/* core/register_file.sv */
`timescale 1ns/1ps

module register_file
	import acc16_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic [1:0]        reg_addr,
	input  logic [15:0]       reg_data,
	input  logic [1:0]        reg_en,
	input  logic [FLAG_W-1:0] next_flags,
	output logic [15:0]       x,
	output logic [15:0]       y,
	output logic [15:0]       z,
	output logic [FLAG_W-1:0] flags
);
	logic [15:0] regs [3];

	// byte lanes written independently
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			regs[0] <= '0;
			regs[1] <= '0;
			regs[2] <= '0;
		end
		else
		begin
			if (reg_en[0])
				regs[reg_addr][7:0] <= reg_data[7:0];
			if (reg_en[1])
				regs[reg_addr][15:8] <= reg_data[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];

endmodule

/* design/acc16_cpu.sv */
`timescale 1ns/1ps

module acc16_cpu
	import acc16_pkg::*;
#(
	parameter int ADDR_W = 16
) (
	input  logic              clk,
	input  logic              reset,
	output logic [ADDR_W-1:0] iread_addr,
	input  logic [INST_W-1:0] iread_data,
	output logic [ADDR_W-1:0] dread_addr,
	input  logic [15:0]       dread_data,
	output logic [ADDR_W-1:0] dwrite_addr,
	output logic [15:0]       dwrite_data,
	output logic [1:0]        dwrite_en,
	output logic              trap
);
	logic [INST_W-1:0] inst;
	logic [FLAG_W-1:0] flags;
	logic [FLAG_W-1:0] next_flags;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] z;
	logic [1:0] reg_addr;
	logic [15:0] reg_data;
	logic [1:0] reg_en;

	alu_if alu_bus ();

	fetch_unit #(
		.ADDR_W(ADDR_W)
	) i_fetch_unit (
		.clk       (clk),
		.reset     (reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.inst      (inst),
		.next_flags(next_flags),
		.dread_addr(dread_addr)
	);

	decoder #(
		.ADDR_W(ADDR_W)
	) i_decoder (
		.clk        (clk),
		.reset      (reset),
		.inst       (inst),
		.dread_data (dread_data),
		.x          (x),
		.y          (y),
		.z          (z),
		.flags      (flags),
		.next_flags (next_flags),
		.alu        (alu_bus.decoder_mp),
		.reg_addr   (reg_addr),
		.reg_data   (reg_data),
		.reg_en     (reg_en),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en  (dwrite_en),
		.trap       (trap)
	);

	alu i_alu (
		.alu(alu_bus.alu_mp)
	);

	register_file i_register_file (
		.clk       (clk),
		.reset     (reset),
		.reg_addr  (reg_addr),
		.reg_data  (reg_data),
		.reg_en    (reg_en),
		.next_flags(next_flags),
		.x         (x),
		.y         (y),
		.z         (z),
		.flags     (flags)
	);

endmodule

/* sim/acc16_cpu_props.sv */
`timescale 1ns/1ps

module acc16_cpu_props
	import acc16_pkg::*;
#(
	parameter int ADDR_W = 16
) (
	input logic              clk,
	input logic              reset,
	input logic [ADDR_W-1:0] iread_addr,
	input logic [1:0]        dwrite_en,
	input logic              trap
);
	int fail_count = 0;

	reset_quiet: assert property (@(posedge clk)
		reset |-> (dwrite_en == 2'b00) && (iread_addr == ADDR_W'(RESET_PC)))
	else
	begin
		$error("store or wrong fetch address while reset is high");
		fail_count++;
	end

	// trap is a one-cycle pulse
	trap_pulse: assert property (@(posedge clk) disable iff (reset)
		trap |=> !trap)
	else
	begin
		$error("trap high for two cycles in a row");
		fail_count++;
	end

	enable_legal: assert property (@(posedge clk)
		dwrite_en != 2'b10)
	else
	begin
		$error("store with only the high byte enabled");
		fail_count++;
	end

endmodule

bind acc16_cpu acc16_cpu_props #(.ADDR_W(ADDR_W)) i_acc16_cpu_props (.*);

/* sim/acc16_cpu_tb.sv */
`timescale 1ns/1ps

module acc16_cpu_tb
	import acc16_pkg::*;
();
	logic clk = 1'b0;
	logic reset;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [7:0] imem [0:65535];
	logic [7:0] dmem [0:65535];
	logic [15:0] ia;
	logic [15:0] da;
	logic [15:0] wr_addr [$];
	logic [15:0] wr_data [$];
	logic [1:0] wr_en [$];

	logic [31:0] lfsr = 32'h49e3_3b40;
	logic [15:0] pc_w;
	logic [15:0] trap_at;
	string test_name;
	int budget = 0;
	int cycles = 0;
	int errors = 0;
	int err_base;
	int tests = 0;
	int tests_bad = 0;

	logic [7:0] r;
	logic [7:0] q;
	logic [7:0] k;
	logic [7:0] v0;
	logic [7:0] v1;
	logic [7:0] v2;
	logic [7:0] v3;
	logic [7:0] v4;
	logic [7:0] v5;
	logic [7:0] xl;
	logic [7:0] cnt;
	logic [15:0] w;
	logic [15:0] a_addr;
	logic [15:0] b_addr;
	logic [15:0] c_addr;
	logic [15:0] z_addr;
	logic [15:0] p_addr;
	logic [15:0] loop_at;
	int idx;

	acc16_cpu #(
		.ADDR_W(16)
	) i_acc16_cpu (
		.clk        (clk),
		.reset      (reset),
		.iread_addr (iread_addr),
		.iread_data (iread_data),
		.dread_addr (dread_addr),
		.dread_data (dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en  (dwrite_en),
		.trap       (trap)
	);

	always #2 clk = ~clk;

	// both memories answer one cycle after the address, writes land at the edge
	always @(posedge clk)
	begin
		ia = iread_addr;
		da = dread_addr;
		if (dwrite_en != 2'b00)
		begin
			if (dwrite_en[0])
				dmem[dwrite_addr] = dwrite_data[7:0];
			if (dwrite_en[1])
				dmem[dwrite_addr + 16'd1] = dwrite_data[15:8];
			wr_addr.push_back(dwrite_addr);
			wr_data.push_back(dwrite_data);
			wr_en.push_back(dwrite_en);
		end
		#0.5;
		iread_data = {imem[ia + 16'd2], imem[ia + 16'd1], imem[ia]};
		dread_data = {dmem[da + 16'd1], dmem[da]};
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > budget)
		begin
			$display("timeout after %0d cycles, a program never reached its trap", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [15:0] rnd(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] disp_to(input logic [15:0] target);
		logic [15:0] d;
		d = target - pc_w - 16'd2;
		return d[7:0];
	endfunction

	task automatic put(input opcode_t op, input logic [15:0] arg);
		imem[pc_w] = op;
		if (inst_len(op) > 2'd1)
			imem[pc_w + 16'd1] = arg[7:0];
		if (inst_len(op) > 2'd2)
			imem[pc_w + 16'd2] = arg[15:8];
		if (op == OP_TRAP)
			trap_at = pc_w;
		pc_w = pc_w + 16'(inst_len(op));
		budget += 50;
	endtask

	task automatic check(input string what, input logic [15:0] exp, input logic [15:0] act,
			input logic [15:0] mask);
		assert ((act & mask) === (exp & mask))
		else
		begin
			$display("Fail %s %s expected %h actual %h", test_name, what, exp & mask,
				act & mask);
			errors++;
		end
	endtask

	task automatic check_write(input int i, input logic [15:0] addr, input logic [15:0] data,
			input logic [1:0] en, input logic [15:0] mask);
		assert (i < wr_addr.size())
		else
		begin
			$display("%s: store number %0d never happened", test_name, i);
			errors++;
		end
		if (i < wr_addr.size())
		begin
			check("store address", addr, wr_addr[i], 16'hffff);
			check("store data", data, wr_data[i], mask);
			check("store enable", 16'(en), 16'(wr_en[i]), 16'h0003);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_base = errors;
		reset = 1'b1;
		for (int i = 0; i < 65536; i++)
			imem[i] = 8'h00;
		wr_addr.delete();
		wr_data.delete();
		wr_en.delete();
		pc_w = RESET_PC;
	endtask

	// releases reset, runs to trap, then watches a few cycles for stray stores
	task automatic run_test();
		int n;
		int last_fetch;
		int wcount;
		budget += 10;
		repeat (3) @(posedge clk);
		#0.5;
		check("reset fetch address", RESET_PC, iread_addr, 16'hffff);
		reset = 1'b0;
		n = 0;
		last_fetch = -100;
		do
		begin
			@(posedge clk);
			#0.5;
			n++;
			if (ia === trap_at)
				last_fetch = n;
		end
		while (trap !== 1'b1);
		check("trap cycle", 16'(last_fetch + 2), 16'(n), 16'hffff);
		wcount = wr_addr.size();
		repeat (3) @(posedge clk);
		#0.5;
		check("stores after trap", 16'(wcount), 16'(wr_addr.size()), 16'hffff);
	endtask

	task automatic end_test();
		tests++;
		if (errors != err_base)
			tests_bad++;
		$display("%s: %0d errors", test_name, errors - err_base);
	endtask

	initial
	begin
		reset = 1'b1;
		iread_data = '0;
		dread_data = '0;

		start_test("reset");
		r = 8'(rnd(8));
		q = 8'(rnd(8));
		a_addr = rnd(16);
		put(OP_NOP, 0);
		put(OP_NOP, 0);
		put(OP_LD_XL_IMMD, r);
		put(OP_XOR_XL_IMMD, q);
		put(OP_LD_DIR_XL, a_addr);
		put(OP_TRAP, 0);
		run_test();
		check("store count", 16'd1, 16'(wr_addr.size()), 16'hffff);
		check_write(0, a_addr, {8'h00, r ^ q}, 2'b01, 16'h00ff);
		end_test();

		start_test("byte arithmetic");
		v0 = 8'(rnd(8));
		v1 = 8'(rnd(8));
		v2 = 8'(rnd(8));
		v3 = 8'(rnd(8));
		v4 = 8'(rnd(8));
		v5 = 8'(rnd(8));
		a_addr = rnd(16);
		put(OP_LD_XL_IMMD, v0);
		put(OP_ADD_XL_IMMD, v1);
		put(OP_SUB_XL_IMMD, v2);
		put(OP_AND_XL_IMMD, v3);
		put(OP_OR_XL_IMMD, v4);
		put(OP_XOR_XL_IMMD, v5);
		put(OP_INC_XL, 0);
		put(OP_LD_DIR_XL, a_addr);
		put(OP_TRAP, 0);
		run_test();
		xl = v0 + v1;
		xl = xl - v2;
		xl = ((xl & v3) | v4) ^ v5;
		xl = xl + 8'd1;
		check("store count", 16'd1, 16'(wr_addr.size()), 16'hffff);
		check_write(0, a_addr, {8'h00, xl}, 2'b01, 16'h00ff);
		end_test();

		start_test("memory load");
		a_addr = 16'h1000 | rnd(8);
		b_addr = 16'h2000 | rnd(8);
		v0 = 8'(rnd(8));
		k = 8'(rnd(8));
		dmem[a_addr] = v0;
		dmem[a_addr + 16'd1] = 8'(rnd(8));
		put(OP_LD_XL_DIR, a_addr);
		put(OP_ADD_XL_IMMD, k);
		put(OP_LD_DIR_XL, b_addr);
		put(OP_TRAP, 0);
		run_test();
		xl = v0 + k;
		check_write(0, b_addr, {8'h00, xl}, 2'b01, 16'h00ff);
		end_test();

		// x clears on reset and only xl is ever loaded
		start_test("word ops");
		r = 8'(rnd(8));
		w = rnd(16);
		a_addr = rnd(16);
		put(OP_LD_XL_IMMD, r);
		put(OP_LDW_Y_IMMD, w);
		put(OP_ADDW_Y_X, 0);
		put(OP_LDW_DIR_Y, a_addr);
		put(OP_TRAP, 0);
		run_test();
		w = w + {8'h00, r};
		check("store count", 16'd1, 16'(wr_addr.size()), 16'hffff);
		check_write(0, a_addr, w, 2'b11, 16'hffff);
		end_test();

		start_test("branches");
		a_addr = 16'h1000 | rnd(8);
		c_addr = 16'h2000 | rnd(8);
		z_addr = 16'h3000 | rnd(8);
		p_addr = 16'h5000 | rnd(8);
		cnt = 8'd3 + 8'(rnd(2));
		v0 = 8'(rnd(8));
		k = 8'(rnd(8));
		v2 = 8'(rnd(8));
		q = rnd(1) ? v2 : 8'(rnd(8));
		put(OP_LD_XL_IMMD, cnt);
		loop_at = pc_w;
		put(OP_LD_DIR_XL, a_addr);
		put(OP_SUB_XL_IMMD, 1);
		put(OP_JRNZ_D, disp_to(loop_at));
		put(OP_JR_D, 3);
		put(OP_LD_DIR_XL, p_addr);
		put(OP_LD_XL_IMMD, v0);
		put(OP_ADD_XL_IMMD, k);
		put(OP_JRC_D, 3);
		put(OP_LD_DIR_XL, c_addr);
		put(OP_LD_XL_IMMD, v2);
		put(OP_SUB_XL_IMMD, q);
		put(OP_JRZ_D, 3);
		put(OP_LD_DIR_XL, z_addr);
		put(OP_TRAP, 0);
		run_test();
		idx = 0;
		for (int i = 0; i < cnt; i++)
		begin
			check_write(idx, a_addr, 16'(cnt - 8'(i)), 2'b01, 16'h00ff);
			idx++;
		end
		if (({1'b0, v0} + {1'b0, k}) < 9'd256)
		begin
			xl = v0 + k;
			check_write(idx, c_addr, {8'h00, xl}, 2'b01, 16'h00ff);
			idx++;
		end
		if (v2 != q)
		begin
			xl = v2 - q;
			check_write(idx, z_addr, {8'h00, xl}, 2'b01, 16'h00ff);
			idx++;
		end
		check("store count", 16'(idx), 16'(wr_addr.size()), 16'hffff);
		foreach (wr_addr[i])
		begin
			assert (wr_addr[i] !== p_addr)
			else
			begin
				$display("%s: skipped store to %h was executed", test_name, p_addr);
				errors++;
			end
		end
		end_test();

		start_test("trap");
		put(OP_NOP, 0);
		put(OP_LD_XL_IMMD, rnd(8));
		put(OP_TRAP, 0);
		run_test();
		check("store count", 16'd0, 16'(wr_addr.size()), 16'hffff);
		end_test();

		$display("%0d tests, %0d failed, %0d errors, %0d property failures", tests, tests_bad,
			errors, i_acc16_cpu.i_acc16_cpu_props.fail_count);
		if (errors == 0 && i_acc16_cpu.i_acc16_cpu_props.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* acc16_cpu.f */
common/acc16_pkg.sv
common/alu_if.sv
core/alu.sv
core/decoder.sv
core/fetch_unit.sv
core/register_file.sv
design/acc16_cpu.sv
sim/acc16_cpu_props.sv
sim/acc16_cpu_tb.sv

/* Bender.yml */
package:
  name: acc16_cpu

sources:
  - common/acc16_pkg.sv
  - common/alu_if.sv
  - core/alu.sv
  - core/decoder.sv
  - core/fetch_unit.sv
  - core/register_file.sv
  - design/acc16_cpu.sv
  - target: test
    files:
      - sim/acc16_cpu_props.sv
      - sim/acc16_cpu_tb.sv
